// ==== hps_pkg.sv ====
package hps_pkg;

	////////////////////
	// link widths

	// one word on the host bus
	typedef logic [15:0] host_word_t;

	// data word position, command word is 0, saturates at 15
	typedef logic [3:0]  word_idx_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [15:0] cfg_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ps2_byte_t;

	////////////////////
	// word sequencer states

	typedef enum logic [1:0] {
		LINK_IDLE,
		LINK_CMD,
		LINK_DATA
	} link_state_t;

	////////////////////
	// user channel commands

	localparam host_word_t CMD_CFG    = 16'h0001;
	localparam host_word_t CMD_JOY0   = 16'h0002;
	localparam host_word_t CMD_JOY1   = 16'h0003;
	localparam host_word_t CMD_KBD    = 16'h0005;
	localparam host_word_t CMD_STATUS = 16'h001E;

	// file channel commands
	localparam host_word_t FIO_FILE_TX     = 16'h0053;
	localparam host_word_t FIO_FILE_TX_DAT = 16'h0054;
	localparam host_word_t FIO_FILE_INDEX  = 16'h0055;

endpackage

// ==== hps_cmd_fsm.sv ====
`timescale 1ns/1ps

module hps_cmd_fsm import hps_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       io_enable,
	input  logic       fp_enable,
	input  logic       io_strobe,
	input  host_word_t io_din,
	output logic       word_valid,
	output host_word_t word_cmd,
	output word_idx_t  word_idx,
	output host_word_t word_data,
	output logic       word_fio
);

	link_state_t state;
	logic        link_on;

	// either channel keeps the transaction open
	assign link_on = io_enable | fp_enable;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= LINK_IDLE;
			word_valid <= 1'b0;
			word_cmd   <= '0;
			word_idx   <= '0;
			word_data  <= '0;
			word_fio   <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			word_fio   <= fp_enable;
			if (!link_on) begin
				state <= LINK_IDLE;
			end else begin
				case (state)
					LINK_IDLE: begin
						// channel just opened
						state <= LINK_CMD;
					end
					LINK_CMD: begin
						// first strobe of a transaction carries the command
						if (io_strobe) begin
							word_cmd <= io_din;
							word_idx <= '0;
							state    <= LINK_DATA;
						end
					end
					LINK_DATA: begin
						if (io_strobe) begin
							word_data  <= io_din;
							word_valid <= 1'b1;
							if (word_idx != '1) begin
								word_idx <= word_idx + 1'b1;
							end
						end
					end
					default: begin
						state <= LINK_IDLE;
					end
				endcase
			end
		end
	end

	////////////////////
	// checks

	// the host opens only one channel at a time
	a_one_channel: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!(io_enable && fp_enable)
	);

	// data pulses only come out of an open transaction
	a_valid_in_link: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		word_valid |-> state != LINK_IDLE
	);

endmodule

// ==== hps_input_regs.sv ====
`timescale 1ns/1ps

module hps_input_regs import hps_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       word_valid,
	input  host_word_t word_cmd,
	input  word_idx_t  word_idx,
	input  host_word_t word_data,
	input  logic       word_fio,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output status_t    status,
	output logic       kbd_we,
	output ps2_byte_t  kbd_byte
);

	cfg_t cfg;
	logic user_word;

	// file channel words belong to the loader
	assign user_word = word_valid & ~word_fio;

	// cfg bits 2, 3 and 5 and up are not used by the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			kbd_we     <= 1'b0;
			kbd_byte   <= '0;
		end else begin
			kbd_we <= 1'b0;
			if (user_word) begin
				case (word_cmd)
					CMD_CFG: begin
						cfg <= word_data;
					end
					CMD_JOY0: begin
						if (word_idx == 4'd1) joystick_0[15:0] <= word_data;
						else joystick_0[31:16] <= word_data;
					end
					CMD_JOY1: begin
						if (word_idx == 4'd1) joystick_1[15:0] <= word_data;
						else joystick_1[31:16] <= word_data;
					end
					CMD_STATUS: begin
						// four slices, low first, anything past them is ignored
						case (word_idx)
							4'd1: status[15:0]  <= word_data;
							4'd2: status[31:16] <= word_data;
							4'd3: status[47:32] <= word_data;
							4'd4: status[63:48] <= word_data;
							default: ;
						endcase
					end
					CMD_KBD: begin
						kbd_we   <= 1'b1;
						kbd_byte <= word_data[7:0];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hps_file_loader.sv ====
`timescale 1ns/1ps

module hps_file_loader import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        word_valid,
	input  host_word_t  word_cmd,
	input  word_idx_t   word_idx,
	input  host_word_t  word_data,
	input  logic        word_fio,
	output logic        ioctl_download,
	output host_word_t  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output ps2_byte_t   ioctl_dout
);

	// address of the next byte to be written
	ioctl_addr_t next_addr;
	logic        file_word;

	assign file_word = word_valid & word_fio;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			next_addr      <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (file_word) begin
				case (word_cmd)
					FIO_FILE_INDEX: begin
						ioctl_index <= word_data;
					end
					FIO_FILE_TX: begin
						case (word_idx)
							4'd1: begin
								if (word_data[7:0] != 8'h00) begin
									next_addr      <= '0;
									ioctl_download <= 1'b1;
								end else begin
									// leave the address just past the last byte
									if (ioctl_download) ioctl_addr <= next_addr;
									ioctl_download <= 1'b0;
								end
							end
							4'd2: begin
								ioctl_addr[15:0] <= word_data;
								next_addr[15:0]  <= word_data;
							end
							4'd3: begin
								ioctl_addr[26:16] <= word_data[10:0];
								next_addr[26:16]  <= word_data[10:0];
							end
							default: ;
						endcase
					end
					FIO_FILE_TX_DAT: begin
						// data outside a download is dropped
						if (ioctl_download) begin
							ioctl_addr <= next_addr;
							ioctl_dout <= word_data[7:0];
							ioctl_wr   <= 1'b1;
							next_addr  <= next_addr + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// writes only happen inside an open download
	a_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> ioctl_download
	);

endmodule

// ==== ps2_clk_gen.sv ====
`timescale 1ns/1ps

module ps2_clk_gen #(
	parameter int PS2DIV = 1000
) (
	input  logic clk_sys,
	input  logic arst_n,
	output logic ps2_tick,
	output logic ps2_phase
);

	localparam int CNT_W = $clog2(PS2DIV + 2);

	logic [CNT_W-1:0] cnt;

	// phase toggles every PS2DIV+1 cycles, tick marks the rising half
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt       <= CNT_W'(PS2DIV);
			ps2_phase <= 1'b0;
			ps2_tick  <= 1'b0;
		end else begin
			ps2_tick <= 1'b0;
			if (cnt == '0) begin
				cnt       <= CNT_W'(PS2DIV);
				ps2_phase <= ~ps2_phase;
				ps2_tick  <= ~ps2_phase;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

// ==== ps2_kbd_tx.sv ====
`timescale 1ns/1ps

module ps2_kbd_tx import hps_pkg::*; #(
	parameter int PS2_FIFO_BITS = 4
) (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      kbd_we,
	input  ps2_byte_t kbd_byte,
	input  logic      ps2_tick,
	input  logic      ps2_phase,
	output logic      ps2_kbd_clk_out,
	output logic      ps2_kbd_data_out
);

	localparam int DEPTH = 1 << PS2_FIFO_BITS;

	ps2_byte_t              fifo [DEPTH];
	logic [PS2_FIFO_BITS-1:0] wptr;
	logic [PS2_FIFO_BITS-1:0] rptr;
	logic [PS2_FIFO_BITS:0]   fill;
	logic                     push;
	logic                     pop;

	// 0 idle, 1 start bit, 2..9 data, 10 parity, 11 stop
	logic [3:0] tx_cnt;
	ps2_byte_t  shift;
	logic       parity;

	assign push = kbd_we && (fill != DEPTH[PS2_FIFO_BITS:0]);
	assign pop  = ps2_tick && (tx_cnt == 4'd0 || tx_cnt == 4'd11) && (fill != '0);

	// clock goes low in the second half of each bit of a frame
	assign ps2_kbd_clk_out = ~((tx_cnt != 4'd0) & ~ps2_phase);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				fifo[i] <= '0;
			end
		end else if (push) begin
			fifo[wptr] <= kbd_byte;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wptr <= '0;
			rptr <= '0;
			fill <= '0;
		end else begin
			if (push) wptr <= wptr + 1'b1;
			if (pop) rptr <= rptr + 1'b1;
			fill <= fill + push - pop;
		end
	end

	////////////////////
	// frame serializer

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			tx_cnt           <= 4'd0;
			shift            <= '0;
			parity           <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else if (ps2_tick) begin
			if (pop) begin
				shift            <= fifo[rptr];
				parity           <= 1'b1;
				ps2_kbd_data_out <= 1'b0;
				tx_cnt           <= 4'd1;
			end else if (tx_cnt >= 4'd1 && tx_cnt <= 4'd8) begin
				// data bits go out lsb first
				ps2_kbd_data_out <= shift[0];
				parity           <= parity ^ shift[0];
				shift            <= {1'b0, shift[7:1]};
				tx_cnt           <= tx_cnt + 1'b1;
			end else if (tx_cnt == 4'd9) begin
				ps2_kbd_data_out <= parity;
				tx_cnt           <= 4'd10;
			end else if (tx_cnt == 4'd10) begin
				ps2_kbd_data_out <= 1'b1;
				tx_cnt           <= 4'd11;
			end else begin
				tx_cnt <= 4'd0;
			end
		end
	end

	a_fill_bound: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		fill <= DEPTH
	);

endmodule

// ==== hps_link.sv ====
`timescale 1ns/1ps

module hps_link import hps_pkg::*; #(
	parameter int PS2DIV        = 1000,
	parameter int PS2_FIFO_BITS = 4
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        io_enable,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  host_word_t  io_din,
	output joy_t        joystick_0,
	output joy_t        joystick_1,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output status_t     status,
	output logic        ioctl_download,
	output host_word_t  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output ps2_byte_t   ioctl_dout,
	output logic        ps2_kbd_clk_out,
	output logic        ps2_kbd_data_out
);

	logic       word_valid;
	host_word_t word_cmd;
	word_idx_t  word_idx;
	host_word_t word_data;
	logic       word_fio;
	logic       kbd_we;
	ps2_byte_t  kbd_byte;
	logic       ps2_tick;
	logic       ps2_phase;

	hps_cmd_fsm u_cmd_fsm (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.io_enable  (io_enable),
		.fp_enable  (fp_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.word_valid (word_valid),
		.word_cmd   (word_cmd),
		.word_idx   (word_idx),
		.word_data  (word_data),
		.word_fio   (word_fio)
	);

	hps_input_regs u_input_regs (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.word_valid         (word_valid),
		.word_cmd           (word_cmd),
		.word_idx           (word_idx),
		.word_data          (word_data),
		.word_fio           (word_fio),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.status             (status),
		.kbd_we             (kbd_we),
		.kbd_byte           (kbd_byte)
	);

	hps_file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.word_valid     (word_valid),
		.word_cmd       (word_cmd),
		.word_idx       (word_idx),
		.word_data      (word_data),
		.word_fio       (word_fio),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	ps2_clk_gen #(
		.PS2DIV (PS2DIV)
	) u_ps2_clk_gen (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.ps2_tick  (ps2_tick),
		.ps2_phase (ps2_phase)
	);

	ps2_kbd_tx #(
		.PS2_FIFO_BITS (PS2_FIFO_BITS)
	) u_ps2_kbd_tx (
		.clk_sys          (clk_sys),
		.arst_n           (arst_n),
		.kbd_we           (kbd_we),
		.kbd_byte         (kbd_byte),
		.ps2_tick         (ps2_tick),
		.ps2_phase        (ps2_phase),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

// ==== tb_hps_link.sv ====
`timescale 1ns/1ps

module tb_hps_link import hps_pkg::*; ();

	localparam int PS2DIV        = 1;
	localparam int PS2_FIFO_BITS = 4;
	localparam int N_ROUNDS      = 4;
	localparam int N_CFG         = 8;
	localparam int N_BYTES       = 20;
	localparam int N_KBD         = 16;
	localparam int FRAME_CYCLES  = 11 * 2 * (PS2DIV + 1);

	// every word sent below, command words included
	localparam int BUS_WORDS = N_ROUNDS * (3 + 3 + 6) + N_CFG * 2 + 2 * 3
		+ (2 + 4 + (N_BYTES + 1) + 2 + 3) + (N_KBD + 1);
	localparam int TIMEOUT_CYCLES = BUS_WORDS * 2 + N_KBD * FRAME_CYCLES + 200;

	logic        clk_sys;
	logic        arst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	host_word_t  io_din;
	joy_t        joystick_0;
	joy_t        joystick_1;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	status_t     status;
	logic        ioctl_download;
	host_word_t  ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ps2_byte_t   ioctl_dout;
	logic        ps2_kbd_clk_out;
	logic        ps2_kbd_data_out;

	// reference model state
	joy_t        m_joy0;
	joy_t        m_joy1;
	status_t     m_status;
	cfg_t        m_cfg;
	host_word_t  m_index;
	logic        m_download;
	ioctl_addr_t m_addr;
	ioctl_addr_t m_next;
	ps2_byte_t   m_dout;
	ioctl_addr_t wr_addr_q[$];
	ps2_byte_t   wr_data_q[$];
	ps2_byte_t   kbd_q[$];
	host_word_t  tx_words[$];

	integer      seed;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          wr_count = 0;
	int          frames_rx = 0;
	int          bit_cnt = 0;
	logic        clk_prev = 1'b1;
	logic [10:0] frame_bits;

	hps_link #(
		.PS2DIV        (PS2DIV),
		.PS2_FIFO_BITS (PS2_FIFO_BITS)
	) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic host_word_t rand_word();
		return host_word_t'($random(seed));
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	////////////////////
	// reference model

	function automatic void apply_word(input logic fio, input host_word_t cmd, input int idx,
			input host_word_t data);
		if (!fio) begin
			case (cmd)
				CMD_CFG: m_cfg = data;
				CMD_JOY0: begin
					if (idx == 1) m_joy0[15:0] = data;
					else m_joy0[31:16] = data;
				end
				CMD_JOY1: begin
					if (idx == 1) m_joy1[15:0] = data;
					else m_joy1[31:16] = data;
				end
				CMD_STATUS: begin
					if (idx >= 1 && idx <= 4) m_status[16 * (idx - 1) +: 16] = data;
				end
				CMD_KBD: kbd_q.push_back(data[7:0]);
				default: ;
			endcase
		end else begin
			case (cmd)
				FIO_FILE_INDEX: m_index = data;
				FIO_FILE_TX: begin
					if (idx == 1 && data[7:0] != 8'h00) begin
						m_download = 1'b1;
						m_next = '0;
					end else if (idx == 1) begin
						m_addr = m_next;
						m_download = 1'b0;
					end else if (idx == 2) begin
						m_addr[15:0] = data;
						m_next[15:0] = data;
					end else if (idx == 3) begin
						m_addr[26:16] = data[10:0];
						m_next[26:16] = data[10:0];
					end
				end
				FIO_FILE_TX_DAT: begin
					if (m_download) begin
						wr_addr_q.push_back(m_next);
						wr_data_q.push_back(data[7:0]);
						m_addr = m_next;
						m_dout = data[7:0];
						m_next = m_next + 1'b1;
					end
				end
				default: ;
			endcase
		end
	endfunction

	task automatic check_regs();
		check_val("joystick_0", m_joy0, joystick_0);
		check_val("joystick_1", m_joy1, joystick_1);
		check_val("status", m_status, status);
		check_val("buttons", m_cfg[1:0], buttons);
		check_val("forced_scandoubler", m_cfg[4], forced_scandoubler);
		check_val("ioctl_download", m_download, ioctl_download);
		check_val("ioctl_index", m_index, ioctl_index);
		check_val("ioctl_addr", m_addr, ioctl_addr);
		check_val("ioctl_dout", m_dout, ioctl_dout);
	endtask

	////////////////////
	// host bus

	task automatic send_word(input host_word_t w);
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b1;
		io_din    = w;
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b0;
	endtask

	// command word first, then tx_words, with an idle cycle after each strobe
	task automatic send_txn(input logic fio, input host_word_t cmd);
		int idx;
		@(posedge clk_sys);
		#2;
		io_enable = !fio;
		fp_enable = fio;
		send_word(cmd);
		for (int i = 0; i < tx_words.size(); i++) begin
			idx = (i + 1 > 15) ? 15 : i + 1;
			apply_word(fio, cmd, idx, tx_words[i]);
			send_word(tx_words[i]);
		end
		tx_words.delete();
		@(posedge clk_sys);
		#2;
		io_enable = 1'b0;
		fp_enable = 1'b0;
	endtask

	////////////////////
	// monitors

	always @(negedge clk_sys) begin
		if (arst_n && ioctl_wr) begin
			wr_count++;
			assert (wr_addr_q.size() > 0) else begin
				$display("ioctl_wr pulse at %0t with no download byte pending", $time);
				errors++;
			end
			if (wr_addr_q.size() > 0) begin
				check_val("ioctl_addr on write", wr_addr_q.pop_front(), ioctl_addr);
				check_val("ioctl_dout on write", wr_data_q.pop_front(), ioctl_dout);
			end
		end
	end

	task automatic decode_frame(input logic [10:0] bits);
		ps2_byte_t data;
		ps2_byte_t exp_byte;
		data = bits[8:1];
		frames_rx++;
		check_val("ps2 start bit", 1'b0, bits[0]);
		check_val("ps2 stop bit", 1'b1, bits[10]);
		assert (kbd_q.size() > 0) else begin
			$display("keyboard frame at %0t with no byte left to send", $time);
			errors++;
		end
		if (kbd_q.size() > 0) begin
			exp_byte = kbd_q.pop_front();
			check_val("ps2 data", exp_byte, data);
			// odd count of ones over data and parity
			check_val("ps2 parity bit", ~^exp_byte, bits[9]);
		end
	endtask

	// falling edge of the ps2 clock seen between two system clock samples
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			clk_prev = 1'b1;
			bit_cnt  = 0;
		end else begin
			if (clk_prev && !ps2_kbd_clk_out) begin
				frame_bits[bit_cnt] = ps2_kbd_data_out;
				bit_cnt++;
				if (bit_cnt == 11) begin
					decode_frame(frame_bits);
					bit_cnt = 0;
				end
			end
			clk_prev = ps2_kbd_clk_out;
		end
	end

	////////////////////
	// tests

	initial begin
		ioctl_addr_t start_addr;
		int          err0;
		int          wr0;
		int          wait_cyc;
		seed       = 32'h81a9_61df;
		arst_n     = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		m_joy0     = '0;
		m_joy1     = '0;
		m_status   = '0;
		m_cfg      = '0;
		m_index    = '0;
		m_download = 1'b0;
		m_addr     = '0;
		m_next     = '0;
		m_dout     = '0;
		repeat (5) @(posedge clk_sys);
		#2;
		arst_n = 1'b1;

		err0 = errors;
		check_regs();
		check_val("ioctl_wr", 1'b0, ioctl_wr);
		check_val("ps2_kbd_clk_out", 1'b1, ps2_kbd_clk_out);
		check_val("ps2_kbd_data_out", 1'b1, ps2_kbd_data_out);
		report_test("reset values", err0);

		err0 = errors;
		for (int r = 0; r < N_ROUNDS; r++) begin
			tx_words.push_back(rand_word());
			tx_words.push_back(rand_word());
			send_txn(1'b0, CMD_JOY0);
			check_regs();
			tx_words.push_back(rand_word());
			tx_words.push_back(rand_word());
			send_txn(1'b0, CMD_JOY1);
			check_regs();
			// fifth status word lands past the last slice
			for (int k = 0; k < 5; k++) tx_words.push_back(rand_word());
			send_txn(1'b0, CMD_STATUS);
			check_regs();
		end
		report_test("joysticks and status", err0);

		err0 = errors;
		for (int r = 0; r < N_CFG; r++) begin
			tx_words.push_back(rand_word());
			send_txn(1'b0, CMD_CFG);
			check_regs();
		end
		// user codes on the file channel
		tx_words.push_back(rand_word());
		tx_words.push_back(rand_word());
		send_txn(1'b1, CMD_CFG);
		check_regs();
		tx_words.push_back(rand_word());
		tx_words.push_back(rand_word());
		send_txn(1'b1, CMD_JOY0);
		check_regs();
		report_test("configuration", err0);

		err0 = errors;
		tx_words.push_back(rand_word());
		send_txn(1'b1, FIO_FILE_INDEX);
		check_regs();
		start_addr = ioctl_addr_t'($random(seed));
		tx_words.push_back(rand_word() | 16'h0001);
		tx_words.push_back(start_addr[15:0]);
		tx_words.push_back({5'd0, start_addr[26:16]});
		send_txn(1'b1, FIO_FILE_TX);
		check_regs();
		check_val("ioctl_addr", start_addr, ioctl_addr);
		wr0 = wr_count;
		for (int k = 0; k < N_BYTES; k++) tx_words.push_back(rand_word());
		send_txn(1'b1, FIO_FILE_TX_DAT);
		wait_cycles(2);
		check_regs();
		check_val("write count", N_BYTES, wr_count - wr0);
		tx_words.push_back(rand_word() & 16'hff00);
		send_txn(1'b1, FIO_FILE_TX);
		check_regs();
		check_val("ioctl_download", 1'b0, ioctl_download);
		// data with no download open
		tx_words.push_back(rand_word());
		tx_words.push_back(rand_word());
		send_txn(1'b1, FIO_FILE_TX_DAT);
		wait_cycles(2);
		check_regs();
		check_val("write count", N_BYTES, wr_count - wr0);
		assert (wr_addr_q.size() == 0) else begin
			$display("%0d download bytes were never written", wr_addr_q.size());
			errors++;
		end
		report_test("download", err0);

		err0 = errors;
		for (int k = 0; k < N_KBD; k++) tx_words.push_back(rand_word());
		send_txn(1'b0, CMD_KBD);
		wait_cyc = 0;
		while (frames_rx < N_KBD && wait_cyc < N_KBD * FRAME_CYCLES + 40) begin
			@(posedge clk_sys);
			wait_cyc++;
		end
		assert (frames_rx == N_KBD) else begin
			$display("keyboard frames missing, %0d of %0d arrived", frames_rx, N_KBD);
			errors++;
		end
		report_test("keyboard", err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
hps_pkg.sv
hps_cmd_fsm.sv
hps_input_regs.sv
hps_file_loader.sv
ps2_clk_gen.sv
ps2_kbd_tx.sv
hps_link.sv
tb_hps_link.sv

// ==== Bender.yml ====
package:
  name: hps_link

sources:
  - files:
      - hps_pkg.sv
      - hps_cmd_fsm.sv
      - hps_input_regs.sv
      - hps_file_loader.sv
      - ps2_clk_gen.sv
      - ps2_kbd_tx.sv
      - hps_link.sv
  - target: simulation
    files:
      - tb_hps_link.sv
